/* rtl/qr_pkg.sv */
package qr_pkg;

  localparam int SAMPLE_W = 13;
  localparam int ROW_IDX_W = 3;
  localparam int K_W = 11;
  localparam int PROD_W = SAMPLE_W + K_W;   // 24 bit product

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [ROW_IDX_W-1:0] row_idx_t;
  typedef logic [2:0] iter_t;               // first micro-rotation, even
  typedef logic [1:0] cordic_dir_t;         // two direction bits per cycle

  // one matrix row, col1 in the upper half
  typedef struct packed {
    sample_t col1;
    sample_t col0;
  } qr_row_t;

  // rows under rotation, x keeps the norm and y is driven to zero
  typedef struct packed {
    qr_row_t x_row;
    qr_row_t y_row;
  } qr_pair_t;

  typedef enum logic [1:0] {
    QR_IDLE = 2'd0,
    QR_CAL  = 2'd1,
    QR_OUT  = 2'd2
  } qr_state_e;

  // cordic gain compensation, 622/1024
  localparam logic signed [K_W-1:0] CORDIC_K = 11'sd622;
  localparam int K_FRAC = 10;

  localparam iter_t LAST_ITER = 3'd6;       // last rotating cycle of a pair

endpackage

/* rtl/givens_cordic.sv */
`timescale 1ns/100ps

module givens_cordic (
  input  qr_pkg::qr_pair_t pair_q,
  input  qr_pkg::iter_t    iter,
  input  logic             scale,
  output qr_pkg::qr_pair_t pair_d
);
  import qr_pkg::*;

  // one micro-rotation, s set means y was non-negative
  function automatic sample_t rot_x(sample_t x, sample_t y, iter_t sh, logic s);
    sample_t ys;
    ys = y >>> sh;
    if (s) begin
      return x + ys;
    end
    return x - ys;
  endfunction

  function automatic sample_t rot_y(sample_t x, sample_t y, iter_t sh, logic s);
    sample_t xs;
    xs = x >>> sh;
    if (s) begin
      return y - xs;
    end
    return y + xs;
  endfunction

  // times K, keep sign and drop one guard bit
  function automatic sample_t k_scale(sample_t v);
    logic signed [PROD_W-1:0] p;
    p = v * CORDIC_K;
    return {p[PROD_W-1], p[K_FRAC+SAMPLE_W-2:K_FRAC]};
  endfunction

  iter_t       iter_b;    // odd partner iteration
  cordic_dir_t dir;
  sample_t     x0_a;
  sample_t     y0_a;
  sample_t     x0_b;
  sample_t     y0_b;
  sample_t     x1_a;
  sample_t     y1_a;
  sample_t     x1_b;
  sample_t     y1_b;

  assign iter_b = iter + 3'd1;

  always_comb begin
    // vectoring on column 0 picks the directions
    dir[0] = ~pair_q.y_row.col0[SAMPLE_W-1];
    x0_a   = rot_x(pair_q.x_row.col0, pair_q.y_row.col0, iter, dir[0]);
    y0_a   = rot_y(pair_q.x_row.col0, pair_q.y_row.col0, iter, dir[0]);
    dir[1] = ~y0_a[SAMPLE_W-1];
    x0_b   = rot_x(x0_a, y0_a, iter_b, dir[1]);
    y0_b   = rot_y(x0_a, y0_a, iter_b, dir[1]);

    // column 1 follows the same directions
    x1_a = rot_x(pair_q.x_row.col1, pair_q.y_row.col1, iter, dir[0]);
    y1_a = rot_y(pair_q.x_row.col1, pair_q.y_row.col1, iter, dir[0]);
    x1_b = rot_x(x1_a, y1_a, iter_b, dir[1]);
    y1_b = rot_y(x1_a, y1_a, iter_b, dir[1]);

    if (scale) begin
      pair_d.x_row.col0 = k_scale(pair_q.x_row.col0);
      pair_d.y_row.col0 = k_scale(pair_q.y_row.col0);
      pair_d.x_row.col1 = k_scale(pair_q.x_row.col1);
      pair_d.y_row.col1 = k_scale(pair_q.y_row.col1);
    end else begin
      pair_d.x_row.col0 = x0_b;
      pair_d.y_row.col0 = y0_b;
      pair_d.x_row.col1 = x1_b;
      pair_d.y_row.col1 = y1_b;
    end
  end

endmodule

/* rtl/qr_row_store.sv */
`timescale 1ns/100ps

module qr_row_store #(
  parameter int NUM_ROWS = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_en,
  input  logic             wb_en,
  input  qr_pkg::row_idx_t rw_idx,
  input  qr_pkg::row_idx_t pair_idx,
  input  qr_pkg::qr_row_t  load_row,
  input  qr_pkg::qr_pair_t pair_d,
  output qr_pkg::qr_pair_t pair_q,
  output qr_pkg::qr_row_t  rd_row
);
  import qr_pkg::*;

  qr_row_t  rows [NUM_ROWS];
  row_idx_t x_idx;

  // x row sits just above the y row
  assign x_idx = pair_idx - 3'd1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        rows[r] <= '0;
      end
    end else begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        if (load_en && (rw_idx == row_idx_t'(r))) begin
          rows[r] <= load_row;
        end else if (wb_en && (x_idx == row_idx_t'(r))) begin
          rows[r] <= pair_d.x_row;
        end else if (wb_en && (pair_idx == row_idx_t'(r))) begin
          rows[r] <= pair_d.y_row;
        end
      end
    end
  end

  // combinational reads, pair for the rotator and one row for unload
  always_comb begin
    pair_q.x_row = rows[x_idx];
    pair_q.y_row = rows[pair_idx];
  end

  assign rd_row = rows[rw_idx];

endmodule

/* rtl/qr_sequencer.sv */
`timescale 1ns/100ps

module qr_sequencer #(
  parameter int NUM_ROWS = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             valid,
  output logic             load_en,
  output logic             wb_en,
  output logic             scale,
  output logic             out_valid,
  output qr_pkg::row_idx_t rw_idx,
  output qr_pkg::row_idx_t pair_idx,
  output qr_pkg::iter_t    iter
);
  import qr_pkg::*;

  localparam row_idx_t TOP_IDX = row_idx_t'(NUM_ROWS - 1);

  qr_state_e state;
  qr_state_e state_nxt;
  logic      scale_q;     // pair is in its K cycle
  logic      cal_start;
  logic      cal_done;
  logic      out_done;

  // last row taken, last pair scaled, last row shown
  assign cal_start = (state == QR_IDLE) && valid && (rw_idx == '0);
  assign cal_done  = (state == QR_CAL) && scale_q && (pair_idx == row_idx_t'(1));
  assign out_done  = (state == QR_OUT) && (rw_idx == '0);

  always_comb begin
    state_nxt = state;
    case (state)
      QR_IDLE: begin
        if (cal_start) begin
          state_nxt = QR_CAL;
        end
      end
      QR_CAL: begin
        if (cal_done) begin
          state_nxt = QR_OUT;
        end
      end
      QR_OUT: begin
        if (out_done) begin
          state_nxt = QR_IDLE;
        end
      end
      default: state_nxt = QR_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= QR_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // shared row counter, counts down while loading and while unloading
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rw_idx <= TOP_IDX;
    end else if (load_en || out_valid) begin
      if (rw_idx == '0) begin
        rw_idx <= TOP_IDX;
      end else begin
        rw_idx <= rw_idx - 3'd1;
      end
    end
  end

  // pair walks bottom-up, iter 0/2/4/6 then one held cycle for K
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pair_idx <= TOP_IDX;
      iter     <= '0;
      scale_q  <= 1'b0;
    end else if (state == QR_CAL) begin
      if (scale_q) begin
        scale_q <= 1'b0;
        iter    <= '0;
        if (cal_done) begin
          pair_idx <= TOP_IDX;
        end else begin
          pair_idx <= pair_idx - 3'd1;
        end
      end else if (iter == LAST_ITER) begin
        scale_q <= 1'b1;      // iter holds here
      end else begin
        iter <= iter + 3'd2;
      end
    end
  end

  assign load_en   = (state == QR_IDLE) && valid;
  assign wb_en     = (state == QR_CAL);
  assign scale     = wb_en && scale_q;
  assign out_valid = (state == QR_OUT);

endmodule

/* rtl/qr_cordic_top.sv */
`timescale 1ns/100ps

module qr_cordic_top #(
  parameter int NUM_ROWS = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid,
  input  qr_pkg::qr_row_t in_row,
  output logic            out_valid,
  output qr_pkg::qr_row_t out_row
);
  import qr_pkg::*;

  logic     load_en;
  logic     wb_en;
  logic     scale;
  row_idx_t rw_idx;
  row_idx_t pair_idx;
  iter_t    iter;
  qr_pair_t pair_q;
  qr_pair_t pair_d;
  qr_row_t  rd_row;

  qr_sequencer #(
    .NUM_ROWS (NUM_ROWS)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .load_en   (load_en),
    .wb_en     (wb_en),
    .scale     (scale),
    .out_valid (out_valid),
    .rw_idx    (rw_idx),
    .pair_idx  (pair_idx),
    .iter      (iter)
  );

  qr_row_store #(
    .NUM_ROWS (NUM_ROWS)
  ) u_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_en  (load_en),
    .wb_en    (wb_en),
    .rw_idx   (rw_idx),
    .pair_idx (pair_idx),
    .load_row (in_row),
    .pair_d   (pair_d),
    .pair_q   (pair_q),
    .rd_row   (rd_row)
  );

  givens_cordic u_givens (
    .pair_q (pair_q),
    .iter   (iter),
    .scale  (scale),
    .pair_d (pair_d)
  );

  assign out_row = out_valid ? rd_row : '0;   // quiet bus between matrices

endmodule

/* sim/qr_assertions.sv */
`timescale 1ns/100ps

module qr_assertions (
  input logic             clk,
  input logic             rst_n,
  input logic             load_en,
  input logic             wb_en,
  input logic             scale,
  input logic             out_valid,
  input qr_pkg::row_idx_t pair_idx,
  input qr_pkg::iter_t    iter
);
  import qr_pkg::*;

  int fail_cnt = 0;   // failures seen so far

  // output burst opens only right after pair 1 got its K cycle
  a_out_after_cal: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_valid) |-> $past(scale) && ($past(pair_idx) == row_idx_t'(1)))
  else begin
    $error("output burst not preceded by the scale cycle of the last pair");
    fail_cnt++;
  end

  a_iter_even: assert property (@(posedge clk) disable iff (!rst_n) !iter[0])
  else begin
    $error("odd CORDIC iteration");
    fail_cnt++;
  end

  a_wb_load: assert property (@(posedge clk) disable iff (!rst_n) !(wb_en && load_en))
  else begin
    $error("write-back and load in the same cycle");
    fail_cnt++;
  end

  // first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
  else begin
    $error("out_valid high right after reset release");
    fail_cnt++;
  end

endmodule

bind qr_sequencer qr_assertions u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .load_en   (load_en),
  .wb_en     (wb_en),
  .scale     (scale),
  .out_valid (out_valid),
  .pair_idx  (pair_idx),
  .iter      (iter)
);

/* sim/tb_qr_cordic.sv */
`timescale 1ns/100ps

module tb_qr_cordic;
  import qr_pkg::*;

  localparam int NUM_ROWS = 8;
  localparam int CLK_PERIOD = 100;
  localparam int NUM_RANDOM = 50;
  localparam int NUM_MATRICES = NUM_RANDOM + 2;
  localparam int FIRST_OUT_EDGE = 36;   // counted from the edge taking row 0
  localparam int WAIT_LIMIT = 100;
  localparam int WATCHDOG_CYCLES = NUM_MATRICES * (8 + 36 + 8 + 6) + 200;

  logic    clk;
  logic    rst_n;
  logic    valid;
  qr_row_t in_row;
  logic    out_valid;
  qr_row_t out_row;

  logic [31:0] lcg_state = 32'hed6a;
  int          mat_in [NUM_ROWS][2];    // [row][col]
  int          mat_exp [NUM_ROWS][2];

  qr_cordic_top #(
    .NUM_ROWS (NUM_ROWS)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .in_row    (in_row),
    .out_valid (out_valid),
    .out_row   (out_row)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int rand_range(int lo, int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'(lcg_next() >> 16) % span;   // upper bits, low ones are weak
  endfunction

  function automatic logic rand_bit();
    return rand_range(0, 1) == 1;
  endfunction

  function automatic qr_row_t rand_row();
    qr_row_t r;
    r.col1 = sample_t'(rand_range(-511, 511));
    r.col0 = sample_t'(rand_range(-511, 511));
    return r;
  endfunction

  // back to 13 bit two's complement
  function automatic int wrap13(int v);
    logic signed [12:0] t;
    t = v[12:0];
    return int'(t);
  endfunction

  // times 622/1024, sign bit then product bits 21..10
  function automatic int k_apply(int v);
    int                 p;
    logic [31:0]        pb;
    logic signed [12:0] t;
    p = v * 622;
    pb = p;
    t = {pb[23], pb[21:10]};
    return int'(t);
  endfunction

  // reference QR: pairs bottom-up, micro-rotations 0..7, then K on all four
  task automatic model_qr();
    int   x0;
    int   y0;
    int   x1;
    int   y1;
    int   nx;
    int   ny;
    logic s;
    mat_exp = mat_in;
    for (int p = NUM_ROWS - 1; p >= 1; p--) begin
      x0 = mat_exp[p-1][0];
      y0 = mat_exp[p][0];
      x1 = mat_exp[p-1][1];
      y1 = mat_exp[p][1];
      for (int j = 0; j < 8; j++) begin
        s = (y0 >= 0);
        nx = s ? x0 + (y0 >>> j) : x0 - (y0 >>> j);
        ny = s ? y0 - (x0 >>> j) : y0 + (x0 >>> j);
        x0 = wrap13(nx);
        y0 = wrap13(ny);
        nx = s ? x1 + (y1 >>> j) : x1 - (y1 >>> j);   // column 1 follows col 0
        ny = s ? y1 - (x1 >>> j) : y1 + (x1 >>> j);
        x1 = wrap13(nx);
        y1 = wrap13(ny);
      end
      mat_exp[p-1][0] = k_apply(x0);
      mat_exp[p][0]   = k_apply(y0);
      mat_exp[p-1][1] = k_apply(x1);
      mat_exp[p][1]   = k_apply(y1);
    end
  endtask

  task automatic stop_failed(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      stop_failed($sformatf("Fail at time %0t: %s, got %0h expected %0h",
                            $time, what, got, exp));
    end
  endtask

  // drive on the rising edge, observe on the falling edge
  task automatic tick(logic v, qr_row_t row);
    @(posedge clk);
    valid  <= v;
    in_row <= row;
    @(negedge clk);
  endtask

  task automatic check_quiet();
    check_value(32'(out_valid), 32'd0, "out_valid outside an output burst");
    check_value(32'(out_row), 32'd0, "out_row while out_valid low");
  endtask

  task automatic run_matrix(int idx);
    qr_row_t row;
    qr_row_t exp_row;
    int      n;
    model_qr();
    for (int r = NUM_ROWS - 1; r >= 0; r--) begin
      row.col1 = sample_t'(mat_in[r][1]);
      row.col0 = sample_t'(mat_in[r][0]);
      tick(1'b1, row);
      check_quiet();
    end
    // this edge takes row 0, junk on valid from here until the burst ends
    tick(rand_bit(), rand_row());
    n = 0;
    while (!out_valid) begin
      check_value(32'(out_row), 32'd0, "out_row during calculation");
      if (n >= WAIT_LIMIT) begin
        stop_failed($sformatf("out_valid never came for matrix %0d", idx));
      end
      tick(rand_bit(), rand_row());
      n++;
    end
    check_value(32'(n + 1), 32'(FIRST_OUT_EDGE), "edges from last input row to out_valid");
    for (int r = NUM_ROWS - 1; r >= 0; r--) begin
      exp_row.col1 = sample_t'(mat_exp[r][1]);
      exp_row.col0 = sample_t'(mat_exp[r][0]);
      check_value(32'(out_valid), 32'd1, $sformatf("out_valid dropped at row %0d", r));
      check_value(32'(out_row), 32'(exp_row), $sformatf("matrix %0d row %0d", idx, r));
      if (r > 0) begin
        tick(rand_bit(), rand_row());
      end
    end
  endtask

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    stop_failed("timeout, the run went past its cycle budget");
  end

  initial begin
    int gap;
    rst_n  = 1'b0;
    valid  = 1'b0;
    in_row = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) begin
      tick(1'b0, '0);
      check_quiet();
    end

    // single non-zero entry in column 0
    for (int r = 0; r < NUM_ROWS; r++) begin
      mat_in[r][0] = (r == 5) ? -300 : 0;
      mat_in[r][1] = rand_range(-511, 511);
    end
    run_matrix(0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      mat_in[r][0] = rand_range(-511, -1);
      mat_in[r][1] = rand_range(-511, -1);
    end
    run_matrix(1);   // straight after, no gap

    for (int m = 0; m < NUM_RANDOM; m++) begin
      gap = (m < 5) ? 0 : rand_range(0, 5);
      repeat (gap) begin
        tick(1'b0, rand_row());
        check_quiet();
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
        mat_in[r][0] = rand_range(-511, 511);
        mat_in[r][1] = rand_range(-511, 511);
      end
      run_matrix(m + 2);
    end
    tick(1'b0, '0);
    check_quiet();

    if (dut.u_seq.u_assert.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("%0d sequencer assertion failures", dut.u_seq.u_assert.fail_cnt);
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/qr_pkg.sv
rtl/givens_cordic.sv
rtl/qr_row_store.sv
rtl/qr_sequencer.sv
rtl/qr_cordic_top.sv
sim/qr_assertions.sv
sim/tb_qr_cordic.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_qr_cordic
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
